// ==== bench/lce_cmd_tb.sv ====
/*
 * LCE command engine testbench with a cache memory model and directory stimulus
 * reference function for the expected responses and typed compare tasks
 */
`timescale 1ns/10ps
`default_nettype none

module lce_cmd_tb
  import lce_cmd_pkg::*;
  ();

  localparam int      seed_c         = 83;
  localparam int      rounds_c       = 8;
  localparam int      num_cmds_c     = 2 + 8 * rounds_c;
  localparam int      clear_cycles_c = 400;
  localparam int      cycle_limit_c  = 200 * num_cmds_c + clear_cycles_c;
  localparam lce_id_t my_id_c        = 2'd3;

  typedef struct packed {
    logic       has_resp;
    resp_type_e rtype;
    block_t     data;
    logic       req_pulse;
    logic       uc_pulse;
  } expect_t;

  logic clk_i, reset_i;
  lce_id_t lce_id_i;
  logic ready_o, sync_done_o, req_complete_o, uc_store_complete_o;
  logic cmd_v_i, cmd_yumi_o;
  cmd_type_e cmd_type_i;
  addr_t cmd_addr_i;
  lce_id_t cmd_src_i;
  way_t cmd_way_i;
  coh_state_e cmd_state_i;
  block_t cmd_data_i;
  logic resp_v_o, resp_ready_i;
  resp_type_e resp_type_o;
  addr_t resp_addr_o;
  lce_id_t resp_dst_o, resp_src_o;
  block_t resp_data_o;
  logic tag_v_o, tag_yumi_i;
  tag_op_e tag_op_o;
  index_t tag_index_o;
  way_t tag_way_o;
  coh_state_e tag_state_o;
  ptag_t tag_tag_o;
  logic stat_v_o, stat_yumi_i;
  stat_op_e stat_op_o;
  index_t stat_index_o;
  way_t stat_way_o;
  dirty_t stat_dirty_i;
  logic data_v_o, data_yumi_i;
  data_op_e data_op_o;
  index_t data_index_o;
  way_t data_way_o;
  block_t data_wdata_o, data_rdata_i;

  // cache model
  ptag_t      tag_mem   [sets_c][assoc_c];
  coh_state_e state_mem [sets_c][assoc_c];
  block_t     data_mem  [sets_c][assoc_c];
  dirty_t     dirty_mem [sets_c];

  logic tag_go, stat_go, data_go;
  logic data_rd_pend, stat_rd_pend;
  block_t data_rd_val;
  dirty_t stat_rd_val;
  logic store_v;
  index_t store_idx;
  way_t store_way;
  block_t store_data;
  expect_t expected;
  int cycles, clear_idx, yumi_count, resp_count, req_count, uc_count;

  lce_cmd_top uut (.*);

  // yumi only while the matching valid is high
  assign tag_yumi_i  = tag_v_o & tag_go;
  assign stat_yumi_i = stat_v_o & stat_go;
  assign data_yumi_i = data_v_o & data_go;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_index(input string name, input index_t got, input index_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_tag(input index_t idx, input ptag_t got_tag, input ptag_t exp_tag,
                           input coh_state_e got_st, input coh_state_e exp_st);
    if (got_tag !== exp_tag) begin
      abort_run($sformatf("[FAIL] tag of set %h got %h expected %h", idx, got_tag, exp_tag));
    end
    if (got_st !== exp_st) begin
      abort_run($sformatf("[FAIL] state of set %h got %h expected %h", idx, got_st, exp_st));
    end
  endtask

  task automatic check_resp(input resp_type_e got_t, input resp_type_e exp_t,
                            input addr_t got_a, input addr_t exp_a,
                            input lce_id_t got_dst, input lce_id_t exp_dst,
                            input lce_id_t got_src, input lce_id_t exp_src,
                            input block_t got_d, input block_t exp_d);
    if (got_t !== exp_t) begin
      abort_run($sformatf("[FAIL] resp_type_o got %h expected %h", got_t, exp_t));
    end
    if (got_a !== exp_a) begin
      abort_run($sformatf("[FAIL] resp_addr_o got %h expected %h", got_a, exp_a));
    end
    if (got_dst !== exp_dst) begin
      abort_run($sformatf("[FAIL] resp_dst_o got %h expected %h", got_dst, exp_dst));
    end
    if (got_src !== exp_src) begin
      abort_run($sformatf("[FAIL] resp_src_o got %h expected %h", got_src, exp_src));
    end
    check_block("resp_data_o", got_d, exp_d);
  endtask

  // expected response and pulses for one command taken from the model before it runs
  function automatic expect_t expect_for(input cmd_type_e t, input index_t i, input way_t w);
    expect_t e;
    e = '0;
    case (t)
      e_cmd_sync: begin
        e.has_resp = 1'b1;
        e.rtype = e_resp_sync_ack;
      end
      e_cmd_inv: begin
        e.has_resp = 1'b1;
        e.rtype = e_resp_inv_ack;
      end
      e_cmd_data, e_cmd_set_state_wakeup: begin
        e.has_resp = 1'b1;
        e.rtype = e_resp_coh_ack;
        e.req_pulse = 1'b1;
      end
      e_cmd_writeback: begin
        e.has_resp = 1'b1;
        e.rtype = e_resp_null_wb;
        if (dirty_mem[i][w]) begin
          e.rtype = e_resp_wb;
          e.data = data_mem[i][w];
        end
      end
      e_cmd_uc_store_done: e.uc_pulse = 1'b1;
      default: ;
    endcase
    return e;
  endfunction

  // memory model and compare process on the transfer edge
  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_c; s++) begin
        for (int v = 0; v < assoc_c; v++) begin
          tag_mem[s][v] = ptag_t'($urandom());
          state_mem[s][v] = coh_state_e'(2'($urandom()));
          data_mem[s][v] = {$urandom(), $urandom()};
        end
        dirty_mem[s] = dirty_t'($urandom());
      end
      {data_rd_pend, stat_rd_pend} = 2'b00;
      {cycles, clear_idx, yumi_count, resp_count, req_count, uc_count} = '0;
    end else begin
      cycles++;
      if (cycles > cycle_limit_c) begin
        abort_run($sformatf("timeout after %0d cycles waiting for the DUT", cycles));
      end
      check_bit("ready_o", ready_o, clear_idx == sets_c);
      data_rd_pend = 1'b0;
      stat_rd_pend = 1'b0;
      // clear walk goes through the sets in order
      if (!ready_o && tag_v_o && tag_yumi_i) begin
        check_index("tag_index_o", tag_index_o, index_t'(clear_idx));
      end
      if (!ready_o && stat_v_o && stat_yumi_i) begin
        check_index("stat_index_o", stat_index_o, index_t'(clear_idx));
      end
      if (!ready_o && tag_yumi_i && stat_yumi_i) begin
        clear_idx++;
      end
      if (tag_v_o && tag_yumi_i) begin
        case (tag_op_o)
          e_tag_set_clear: begin
            for (int v = 0; v < assoc_c; v++) begin
              tag_mem[tag_index_o][v] = '0;
              state_mem[tag_index_o][v] = e_coh_i;
            end
          end
          e_tag_set_state: state_mem[tag_index_o][tag_way_o] = tag_state_o;
          e_tag_set_tag: begin
            tag_mem[tag_index_o][tag_way_o] = tag_tag_o;
            state_mem[tag_index_o][tag_way_o] = tag_state_o;
          end
          default: abort_run("tag packet carries an unknown operation");
        endcase
      end
      if (stat_v_o && stat_yumi_i) begin
        case (stat_op_o)
          e_stat_set_clear: dirty_mem[stat_index_o] = '0;
          e_stat_read: begin
            stat_rd_val = dirty_mem[stat_index_o];
            stat_rd_pend = 1'b1;
          end
          e_stat_clear_dirty: dirty_mem[stat_index_o][stat_way_o] = 1'b0;
          default: abort_run("status packet carries an unknown operation");
        endcase
      end
      if (data_v_o && data_yumi_i) begin
        if (data_op_o == e_data_write) begin
          data_mem[data_index_o][data_way_o] = data_wdata_o;
        end else begin
          data_rd_val = data_mem[data_index_o][data_way_o];
          data_rd_pend = 1'b1;
        end
      end
      // processor store between commands makes a block dirty
      if (store_v) begin
        data_mem[store_idx][store_way] = store_data;
        dirty_mem[store_idx][store_way] = 1'b1;
      end
      if (resp_v_o) begin
        check_resp(resp_type_o, expected.rtype, resp_addr_o, cmd_addr_i,
                   resp_dst_o, cmd_src_i, resp_src_o, my_id_c,
                   resp_data_o, expected.data);
        check_bit("cmd_yumi_o with response", cmd_yumi_o, 1'b1);
        check_bit("req_complete_o with response", req_complete_o, expected.req_pulse);
        resp_count++;
      end
      if (req_complete_o) begin
        check_bit("cmd_yumi_o with req_complete_o", cmd_yumi_o, 1'b1);
        req_count++;
      end
      if (uc_store_complete_o) begin
        check_bit("cmd_yumi_o with uc_store_complete_o", cmd_yumi_o, 1'b1);
        uc_count++;
      end
      if (cmd_yumi_o) begin
        yumi_count++;
      end
    end
  end

  // random yumis and back-pressure with read data one cycle after the read yumi
  initial begin
    logic [31:0] r;
    {tag_go, stat_go, data_go, resp_ready_i} = 4'b0000;
    data_rdata_i = '0;
    stat_dirty_i = '0;
    forever begin
      @(negedge clk_i);
      r = $urandom();
      tag_go = r[1:0] != 2'b00;
      stat_go = r[3:2] != 2'b00;
      data_go = r[5:4] != 2'b00;
      resp_ready_i = r[7:6] != 2'b00;
      data_rdata_i = data_rd_pend ? data_rd_val : {$urandom(), $urandom()};
      stat_dirty_i = stat_rd_pend ? stat_rd_val : dirty_t'($urandom());
    end
  end

  task automatic run_cmd(input cmd_type_e t, input addr_t a, input lce_id_t src,
                         input way_t w, input coh_state_e st, input block_t d);
    int start_yumi, start_resp, start_req, start_uc;
    @(negedge clk_i);
    expected = expect_for(t, index_t'(a >> offset_width_c), w);
    start_yumi = yumi_count;
    start_resp = resp_count;
    start_req = req_count;
    start_uc = uc_count;
    cmd_type_i = t;
    cmd_addr_i = a;
    cmd_src_i = src;
    cmd_way_i = w;
    cmd_state_i = st;
    cmd_data_i = d;
    cmd_v_i = 1'b1;
    while (yumi_count == start_yumi) @(negedge clk_i);
    cmd_v_i = 1'b0;
    check_bit("response sent", (resp_count - start_resp) == 1, expected.has_resp);
    check_bit("req_complete_o pulse", (req_count - start_req) == 1, expected.req_pulse);
    check_bit("uc_store_complete_o pulse", (uc_count - start_uc) == 1, expected.uc_pulse);
  endtask

  task automatic cpu_store(input index_t i, input way_t w, input block_t d);
    @(negedge clk_i);
    store_idx = i;
    store_way = w;
    store_data = d;
    store_v = 1'b1;
    @(negedge clk_i);
    store_v = 1'b0;
  endtask

  initial begin
    addr_t a;
    index_t idx;
    way_t w;
    block_t d;
    ptag_t tg;
    coh_state_e st;
    void'($urandom(seed_c));
    reset_i = 1'b1;
    lce_id_i = my_id_c;
    cmd_v_i = 1'b0;
    cmd_type_i = e_cmd_sync;
    cmd_addr_i = '0;
    cmd_src_i = '0;
    cmd_way_i = '0;
    cmd_state_i = e_coh_i;
    cmd_data_i = '0;
    store_v = 1'b0;
    store_idx = '0;
    store_way = '0;
    store_data = '0;
    expected = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    while (!ready_o) @(negedge clk_i);
    for (int s = 0; s < sets_c; s++) begin
      for (int v = 0; v < assoc_c; v++) begin
        check_tag(index_t'(s), tag_mem[s][v], '0, state_mem[s][v], e_coh_i);
      end
      check_bit("dirty bits cleared", dirty_mem[s] == '0, 1'b1);
    end

    // one sync per directory
    check_bit("sync_done_o", sync_done_o, 1'b0);
    run_cmd(e_cmd_sync, addr_t'($urandom()), 2'd0, '0, e_coh_i, '0);
    check_bit("sync_done_o", sync_done_o, 1'b0);
    run_cmd(e_cmd_sync, addr_t'($urandom()), 2'd1, '0, e_coh_i, '0);
    check_bit("sync_done_o", sync_done_o, 1'b1);

    for (int k = 0; k < rounds_c; k++) begin
      a = addr_t'($urandom());
      w = way_t'($urandom());
      d = {$urandom(), $urandom()};
      idx = index_t'(a >> offset_width_c);
      tg = ptag_t'(a >> (offset_width_c + index_width_c));
      run_cmd(e_cmd_data, a, 2'(k), w, e_coh_m, d);
      check_tag(idx, tag_mem[idx][w], tg, state_mem[idx][w], e_coh_m);
      check_block("filled block", data_mem[idx][w], d);
      run_cmd(e_cmd_set_state_wakeup, a, 2'(k), w, e_coh_e, '0);
      check_tag(idx, tag_mem[idx][w], tg, state_mem[idx][w], e_coh_e);
      if (k % 2 == 0) begin
        cpu_store(idx, w, ~d);
      end
      // first writeback is dirty on even rounds and the second one is always clean
      run_cmd(e_cmd_writeback, a, 2'(k + 1), w, e_coh_i, '0);
      check_bit("dirty bit after writeback", dirty_mem[idx][w], 1'b0);
      run_cmd(e_cmd_writeback, a, 2'(k + 1), w, e_coh_i, '0);
      st = coh_state_e'(2'($urandom()));
      run_cmd(e_cmd_set_state, a, 2'(k), w, st, '0);
      check_tag(idx, tag_mem[idx][w], tg, state_mem[idx][w], st);
      run_cmd(e_cmd_inv, a, 2'(k + 2), w, e_coh_m, '0);
      check_tag(idx, tag_mem[idx][w], tg, state_mem[idx][w], e_coh_i);
      run_cmd(e_cmd_set_clear, a, 2'(k), w, e_coh_i, '0);
      for (int v = 0; v < assoc_c; v++) begin
        check_tag(idx, tag_mem[idx][v], '0, state_mem[idx][v], e_coh_i);
      end
      run_cmd(e_cmd_uc_store_done, a, 2'(k), w, e_coh_i, '0);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lce_cmd_top.f ====
rtl/lce_cmd_pkg.sv
rtl/readback_if.sv
rtl/lce_cmd_fsm.sv
rtl/lce_sync_counter.sv
rtl/readback_buf.sv
rtl/lce_cmd_top.sv
bench/lce_cmd_tb.sv

// ==== rtl/lce_cmd_fsm.sv ====
/*
 * LCE command FSM: clears the cache after reset, then decodes directory
 * commands into tag, status and data packets and directory responses
 */
`timescale 1ns/10ps
`default_nettype none

module lce_cmd_fsm
  import lce_cmd_pkg::*;
  (
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire lce_id_t    lce_id_i,
  // inbound command, valid/yumi
  input  wire logic       cmd_v_i,
  input  wire cmd_type_e  cmd_type_i,
  input  wire addr_t      cmd_addr_i,
  input  wire lce_id_t    cmd_src_i,
  input  wire way_t       cmd_way_i,
  input  wire coh_state_e cmd_state_i,
  input  wire block_t     cmd_data_i,
  output logic            cmd_yumi_o,
  // response, ready/valid
  output logic            resp_v_o,
  output resp_type_e      resp_type_o,
  output addr_t           resp_addr_o,
  output lce_id_t         resp_dst_o,
  output lce_id_t         resp_src_o,
  output block_t          resp_data_o,
  input  wire logic       resp_ready_i,
  // cache memory packets, valid/yumi
  output logic            tag_v_o,
  output tag_op_e         tag_op_o,
  output index_t          tag_index_o,
  output way_t            tag_way_o,
  output coh_state_e      tag_state_o,
  output ptag_t           tag_tag_o,
  input  wire logic       tag_yumi_i,
  output logic            stat_v_o,
  output stat_op_e        stat_op_o,
  output index_t          stat_index_o,
  output way_t            stat_way_o,
  input  wire logic       stat_yumi_i,
  output logic            data_v_o,
  output data_op_e        data_op_o,
  output index_t          data_index_o,
  output way_t            data_way_o,
  output block_t          data_wdata_o,
  input  wire logic       data_yumi_i,
  // shared counter
  output logic            cnt_inc_o,
  output logic            cnt_clear_o,
  output logic            sync_done_set_o,
  input  wire cnt_t       cnt_i,
  readback_if.fsm         rb,
  output logic            ready_o,
  output logic            req_complete_o,
  output logic            uc_store_complete_o
  );

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_coh_ack,
    e_wb,
    e_wb_dirty_rd,
    e_wb_dirty_send
  } state_e;

  state_e state_r, state_n;

  index_t cmd_index;
  ptag_t  cmd_tag;
  logic   tag_stat_yumi;
  logic   way_dirty;

  assign cmd_index     = cmd_addr_i[offset_width_c +: index_width_c];
  assign cmd_tag       = cmd_addr_i[addr_width_c-1 -: tag_width_c];
  assign tag_stat_yumi = tag_yumi_i & stat_yumi_i;
  assign way_dirty     = rb.stat_buf[cmd_way_i];

  // commands are taken only once the cache has been cleared
  assign ready_o = (state_r != e_reset) && (state_r != e_clear);

  assign rb.data_rd_accept = data_v_o & data_yumi_i & (data_op_o == e_data_read);
  assign rb.stat_rd_accept = stat_v_o & stat_yumi_i & (stat_op_o == e_stat_read);

  always_comb begin
    state_n = state_r;
    cmd_yumi_o = 1'b0;
    req_complete_o = 1'b0;
    uc_store_complete_o = 1'b0;
    cnt_inc_o = 1'b0;
    cnt_clear_o = 1'b0;
    sync_done_set_o = 1'b0;
    // response header always answers the current command
    resp_v_o = 1'b0;
    resp_type_o = e_resp_sync_ack;
    resp_addr_o = cmd_addr_i;
    resp_dst_o = cmd_src_i;
    resp_src_o = lce_id_i;
    resp_data_o = '0;
    tag_v_o = 1'b0;
    tag_op_o = e_tag_set_clear;
    tag_index_o = cmd_index;
    tag_way_o = cmd_way_i;
    tag_state_o = e_coh_i;
    tag_tag_o = '0;
    stat_v_o = 1'b0;
    stat_op_o = e_stat_set_clear;
    stat_index_o = cmd_index;
    stat_way_o = cmd_way_i;
    data_v_o = 1'b0;
    data_op_o = e_data_read;
    data_index_o = cmd_index;
    data_way_o = cmd_way_i;
    data_wdata_o = '0;

    unique case (state_r)
      e_reset: begin
        cnt_clear_o = 1'b1;
        state_n = e_clear;
      end

      // walk all sets, index taken from the shared counter
      e_clear: begin
        tag_v_o = 1'b1;
        tag_index_o = cnt_i[index_width_c-1:0];
        stat_v_o = 1'b1;
        stat_index_o = cnt_i[index_width_c-1:0];
        if (tag_stat_yumi && (cnt_i == cnt_t'(sets_c - 1))) begin
          cnt_clear_o = 1'b1;
          state_n = e_ready;
        end else begin
          cnt_inc_o = tag_stat_yumi;
        end
      end

      e_ready: begin
        if (cmd_v_i) begin
          unique case (cmd_type_i)
            e_cmd_sync: begin
              resp_v_o = resp_ready_i;
              cmd_yumi_o = resp_v_o;
              // last directory's sync finishes the count
              if (cnt_i == cnt_t'(num_cce_c - 1)) begin
                cnt_clear_o = resp_v_o;
                sync_done_set_o = resp_v_o;
              end else begin
                cnt_inc_o = resp_v_o;
              end
            end
            e_cmd_set_clear: begin
              tag_v_o = 1'b1;
              stat_v_o = 1'b1;
              cmd_yumi_o = tag_stat_yumi;
            end
            e_cmd_inv: begin
              tag_v_o = 1'b1;
              tag_op_o = e_tag_set_state;
              resp_type_o = e_resp_inv_ack;
              resp_v_o = tag_yumi_i & resp_ready_i;
              cmd_yumi_o = resp_v_o;
            end
            e_cmd_set_state: begin
              tag_v_o = 1'b1;
              tag_op_o = e_tag_set_state;
              tag_state_o = cmd_state_i;
              cmd_yumi_o = tag_yumi_i;
            end
            e_cmd_data: begin
              data_v_o = 1'b1;
              data_op_o = e_data_write;
              data_wdata_o = cmd_data_i;
              tag_v_o = 1'b1;
              tag_op_o = e_tag_set_tag;
              tag_state_o = cmd_state_i;
              tag_tag_o = cmd_tag;
              if (tag_yumi_i && data_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_set_state_wakeup: begin
              tag_v_o = 1'b1;
              tag_op_o = e_tag_set_state;
              tag_state_o = cmd_state_i;
              if (tag_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_writeback: begin
              // dirty bits come back through the read-back buffer
              stat_v_o = 1'b1;
              stat_op_o = e_stat_read;
              if (stat_yumi_i) begin
                state_n = e_wb;
              end
            end
            e_cmd_uc_store_done: begin
              cmd_yumi_o = 1'b1;
              uc_store_complete_o = 1'b1;
            end
            default: begin
              state_n = e_ready;
            end
          endcase
        end
      end

      e_coh_ack: begin
        resp_type_o = e_resp_coh_ack;
        resp_v_o = cmd_v_i & resp_ready_i;
        cmd_yumi_o = resp_v_o;
        req_complete_o = resp_v_o;
        if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      // clean way answers right away with a null writeback
      e_wb: begin
        resp_type_o = e_resp_null_wb;
        resp_v_o = cmd_v_i & resp_ready_i & rb.stat_buf_v & ~way_dirty;
        cmd_yumi_o = resp_v_o;
        if (rb.stat_buf_v && way_dirty) begin
          state_n = e_wb_dirty_rd;
        end else if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      e_wb_dirty_rd: begin
        data_v_o = 1'b1;
        stat_v_o = 1'b1;
        stat_op_o = e_stat_clear_dirty;
        if (data_yumi_i && stat_yumi_i) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        resp_type_o = e_resp_wb;
        resp_data_o = rb.data_buf;
        resp_v_o = cmd_v_i & resp_ready_i & rb.data_buf_v;
        cmd_yumi_o = resp_v_o;
        if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

  // a command is only dequeued while the directory presents it
  yumi_needs_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_o |-> cmd_v_i);

  resp_needs_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> resp_ready_i);

endmodule

`default_nettype wire

// ==== rtl/lce_cmd_pkg.sv ====
/*
 * shared widths, vector typedefs and message enums for the LCE command engine
 * also holds the cache memory packet opcodes
 */
`default_nettype none

package lce_cmd_pkg;

  // address and cache geometry
  localparam int addr_width_c   = 16;
  localparam int sets_c         = 16;
  localparam int assoc_c        = 4;
  localparam int block_width_c  = 64;
  localparam int offset_width_c = 3;
  localparam int num_cce_c      = 2;

  // derived field widths
  localparam int lce_id_width_c = 2;
  localparam int index_width_c  = 4;
  localparam int way_width_c    = 2;
  localparam int tag_width_c    = 9;
  // wide enough for the set walk and the directory count
  localparam int cnt_width_c    = 5;

  typedef logic [addr_width_c-1:0]   addr_t;
  typedef logic [index_width_c-1:0]  index_t;
  typedef logic [way_width_c-1:0]    way_t;
  typedef logic [tag_width_c-1:0]    ptag_t;
  typedef logic [lce_id_width_c-1:0] lce_id_t;
  typedef logic [block_width_c-1:0]  block_t;
  typedef logic [assoc_c-1:0]        dirty_t;
  typedef logic [cnt_width_c-1:0]    cnt_t;

  typedef enum logic [1:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m
  } coh_state_e;

  // commands from the directory
  typedef enum logic [2:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_inv,
    e_cmd_set_state,
    e_cmd_data,
    e_cmd_set_state_wakeup,
    e_cmd_writeback,
    e_cmd_uc_store_done
  } cmd_type_e;

  // responses back to the directory
  typedef enum logic [2:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_coh_ack,
    e_resp_wb,
    e_resp_null_wb
  } resp_type_e;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_state,
    e_tag_set_tag
  } tag_op_e;

  typedef enum logic [1:0] {
    e_stat_set_clear,
    e_stat_read,
    e_stat_clear_dirty
  } stat_op_e;

  typedef enum logic {
    e_data_read,
    e_data_write
  } data_op_e;

endpackage

`default_nettype wire

// ==== rtl/lce_cmd_top.sv ====
/*
 * LCE command engine top level: FSM, shared counter and read-back buffer
 */
`timescale 1ns/10ps
`default_nettype none

module lce_cmd_top
  import lce_cmd_pkg::*;
  (
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire lce_id_t    lce_id_i,
  output logic            ready_o,
  output logic            sync_done_o,
  output logic            req_complete_o,
  output logic            uc_store_complete_o,
  // directory command
  input  wire logic       cmd_v_i,
  input  wire cmd_type_e  cmd_type_i,
  input  wire addr_t      cmd_addr_i,
  input  wire lce_id_t    cmd_src_i,
  input  wire way_t       cmd_way_i,
  input  wire coh_state_e cmd_state_i,
  input  wire block_t     cmd_data_i,
  output logic            cmd_yumi_o,
  // directory response
  output logic            resp_v_o,
  output resp_type_e      resp_type_o,
  output addr_t           resp_addr_o,
  output lce_id_t         resp_dst_o,
  output lce_id_t         resp_src_o,
  output block_t          resp_data_o,
  input  wire logic       resp_ready_i,
  // cache memories
  output logic            tag_v_o,
  output tag_op_e         tag_op_o,
  output index_t          tag_index_o,
  output way_t            tag_way_o,
  output coh_state_e      tag_state_o,
  output ptag_t           tag_tag_o,
  input  wire logic       tag_yumi_i,
  output logic            stat_v_o,
  output stat_op_e        stat_op_o,
  output index_t          stat_index_o,
  output way_t            stat_way_o,
  input  wire logic       stat_yumi_i,
  input  wire dirty_t     stat_dirty_i,
  output logic            data_v_o,
  output data_op_e        data_op_o,
  output index_t          data_index_o,
  output way_t            data_way_o,
  output block_t          data_wdata_o,
  input  wire logic       data_yumi_i,
  input  wire block_t     data_rdata_i
  );

  logic cnt_inc;
  logic cnt_clear;
  logic sync_done_set;
  cnt_t cnt;

  readback_if rb_if ();

  lce_cmd_fsm fsm (
    .clk_i, .reset_i, .lce_id_i,
    .cmd_v_i, .cmd_type_i, .cmd_addr_i, .cmd_src_i, .cmd_way_i, .cmd_state_i,
    .cmd_data_i, .cmd_yumi_o,
    .resp_v_o, .resp_type_o, .resp_addr_o, .resp_dst_o, .resp_src_o,
    .resp_data_o, .resp_ready_i,
    .tag_v_o, .tag_op_o, .tag_index_o, .tag_way_o, .tag_state_o, .tag_tag_o,
    .tag_yumi_i,
    .stat_v_o, .stat_op_o, .stat_index_o, .stat_way_o, .stat_yumi_i,
    .data_v_o, .data_op_o, .data_index_o, .data_way_o, .data_wdata_o,
    .data_yumi_i,
    .cnt_inc_o       (cnt_inc),
    .cnt_clear_o     (cnt_clear),
    .sync_done_set_o (sync_done_set),
    .cnt_i           (cnt),
    .rb              (rb_if),
    .ready_o, .req_complete_o, .uc_store_complete_o
  );

  lce_sync_counter counter (
    .clk_i, .reset_i,
    .cnt_inc_i       (cnt_inc),
    .cnt_clear_i     (cnt_clear),
    .sync_done_set_i (sync_done_set),
    .cnt_o           (cnt),
    .sync_done_o
  );

  readback_buf rdbuf (
    .clk_i, .reset_i, .data_rdata_i, .stat_dirty_i,
    .rb (rb_if)
  );

endmodule

`default_nettype wire

// ==== rtl/lce_sync_counter.sv ====
/*
 * shared set-walk and sync counter, plus the sync-done flag
 */
`timescale 1ns/10ps
`default_nettype none

module lce_sync_counter
  import lce_cmd_pkg::*;
  (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic cnt_inc_i,
  input  wire logic cnt_clear_i,
  input  wire logic sync_done_set_i,
  output cnt_t      cnt_o,
  output logic      sync_done_o
  );

  always_ff @(posedge clk_i) begin
    if (reset_i || cnt_clear_i) begin
      cnt_o <= '0;
    end else if (cnt_inc_i) begin
      cnt_o <= cnt_o + cnt_t'(1);
    end
  end

  // stays set once every directory has been acked
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_done_o <= 1'b0;
    end else if (sync_done_set_i) begin
      sync_done_o <= 1'b1;
    end
  end

  inc_clear_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cnt_inc_i && cnt_clear_i));

endmodule

`default_nettype wire

// ==== rtl/readback_buf.sv ====
/*
 * capture registers for data and status read results with valid flags
 */
`timescale 1ns/10ps
`default_nettype none

module readback_buf
  import lce_cmd_pkg::*;
  (
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire block_t data_rdata_i,
  input  wire dirty_t stat_dirty_i,
  readback_if.buffer  rb
  );

  // read data shows up one cycle after the accept
  logic data_cap_r;
  logic stat_cap_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_cap_r    <= 1'b0;
      stat_cap_r    <= 1'b0;
      rb.data_buf_v <= 1'b0;
      rb.stat_buf_v <= 1'b0;
    end else begin
      data_cap_r    <= rb.data_rd_accept;
      stat_cap_r    <= rb.stat_rd_accept;
      // a new accept invalidates the old contents first
      rb.data_buf_v <= (rb.data_buf_v | data_cap_r) & ~rb.data_rd_accept;
      rb.stat_buf_v <= (rb.stat_buf_v | stat_cap_r) & ~rb.stat_rd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_cap_r) begin
      rb.data_buf <= data_rdata_i;
    end
    if (stat_cap_r) begin
      rb.stat_buf <= stat_dirty_i;
    end
  end

  // flag becomes visible two edges after the FSM's accept
  data_v_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(rb.data_buf_v) |-> $past(rb.data_rd_accept, 2));

  stat_v_rise_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(rb.stat_buf_v) |-> $past(rb.stat_rd_accept, 2));

endmodule

`default_nettype wire

// ==== rtl/readback_if.sv ====
/*
 * read-accept strobes and buffered memory read results
 */
`timescale 1ns/10ps
`default_nettype none

interface readback_if
  import lce_cmd_pkg::*;
  ();

  // one-cycle pulses when a read packet is accepted
  logic   data_rd_accept;
  logic   stat_rd_accept;

  block_t data_buf;
  logic   data_buf_v;
  dirty_t stat_buf;
  logic   stat_buf_v;

  modport fsm (output data_rd_accept, stat_rd_accept,
               input  data_buf, data_buf_v, stat_buf, stat_buf_v);

  modport buffer (input  data_rd_accept, stat_rd_accept,
                  output data_buf, data_buf_v, stat_buf, stat_buf_v);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LCE command engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module lce_cmd_tb \
  -f lce_cmd_top.f -o lce_cmd_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lce_cmd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
